// File: Makefile
TOP = tb_arcade_mem

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

obj_dir/V$(TOP): verilog.f design/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

// File: design/arcade_mem_top.sv
`timescale 1ns/1ns

module arcade_mem_top (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [15:0]       dl_addr,
	input  logic [7:0]        dl_data,
	input  logic              reset_btn,
	input  logic              key_strobe,
	input  logic              key_pressed,
	input  logic [7:0]        key_code,
	input  logic [14:0]       cpu_rom_addr,
	input  logic              cpu_rom_rd,
	input  logic [13:0]       snd_rom_addr,
	input  logic              snd_rom_rd,
	output logic [7:0]        cpu_rom_data,
	output logic              cpu_rom_valid,
	output logic [7:0]        snd_rom_data,
	output logic              snd_rom_valid,
	output logic              rom_loaded,
	output logic              core_reset,
	output arcade_pkg::ctrl_t ctrl
);

	logic                 loader_req, cpu_req, snd_req;
	logic                 loader_gnt, cpu_gnt, snd_gnt;
	arcade_pkg::mem_req_t loader_mem_req, cpu_mem_req, snd_mem_req;
	arcade_pkg::mem_req_t mem_req;
	logic                 mem_valid;
	logic                 mem_rvalid;
	logic [15:0]          mem_rdata;
	logic                 cpu_rvalid, snd_rvalid;
	logic [15:0]          rdata;

	// ====================
	// rom download and clients
	// ====================
	rom_loader u_rom_loader (
		.clk_sys, .arst_n, .dl_active, .dl_wr, .dl_addr, .dl_data, .reset_btn,
		.gnt(loader_gnt), .req(loader_req), .wr_req(loader_mem_req),
		.rom_loaded, .core_reset
	);

	rom_fetch_port #(.ADDR_W(15), .BASE(0)) u_cpu_port (
		.clk_sys, .arst_n, .dl_active,
		.rd(cpu_rom_rd), .addr(cpu_rom_addr),
		.gnt(cpu_gnt), .rvalid(cpu_rvalid), .rdata,
		.req(cpu_req), .rd_req(cpu_mem_req),
		.data(cpu_rom_data), .valid(cpu_rom_valid)
	);

	rom_fetch_port #(.ADDR_W(14), .BASE(arcade_pkg::SND_ROM_BASE)) u_snd_port (
		.clk_sys, .arst_n, .dl_active,
		.rd(snd_rom_rd), .addr(snd_rom_addr),
		.gnt(snd_gnt), .rvalid(snd_rvalid), .rdata,
		.req(snd_req), .rd_req(snd_mem_req),
		.data(snd_rom_data), .valid(snd_rom_valid)
	);

	// ====================
	// shared memory
	// ====================
	mem_arbiter u_mem_arbiter (
		.clk_sys, .arst_n, .loader_req, .cpu_req, .snd_req,
		.loader_mem_req, .cpu_mem_req, .snd_mem_req, .mem_rvalid, .mem_rdata,
		.loader_gnt, .cpu_gnt, .snd_gnt, .mem_req, .mem_valid,
		.loader_rvalid(), .cpu_rvalid, .snd_rvalid, .rdata
	);

	rom_store #(.DEPTH(2 * arcade_pkg::CPU_ROM_WORDS)) u_rom_store (
		.clk_sys, .mem_valid, .mem_req, .rvalid(mem_rvalid), .rdata(mem_rdata)
	);

	key_mapper u_key_mapper (
		.clk_sys, .arst_n, .key_strobe, .key_pressed, .key_code, .ctrl
	);

endmodule

// File: design/arcade_pkg.sv
package arcade_pkg;

	// ====================
	// memory access
	// ====================

	typedef logic [14:0] mem_addr_t; // 16-bit word address

	typedef struct packed {
		logic        wr;
		mem_addr_t   addr;
		logic [1:0]  be;    // bit 1 selects the high byte
		logic [15:0] wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		loader = 2'd0,
		cpu    = 2'd1,
		snd    = 2'd2
	} req_id_t;

	// player control levels
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic shot_up;
		logic shot_left;
		logic shot_down;
		logic shot_right;
		logic coin;
		logic start1;
		logic start2;
	} ctrl_t;

	localparam int CPU_ROM_WORDS = 16384;
	localparam int SND_ROM_BASE  = CPU_ROM_WORDS; // sound rom right after cpu rom
	localparam int MEM_LATENCY   = 2;             // grant to read data

endpackage

// File: design/key_mapper.sv
`timescale 1ns/1ns

module key_mapper (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              key_strobe,
	input  logic              key_pressed,
	input  logic [7:0]        key_code,
	output arcade_pkg::ctrl_t ctrl
);

	// make sets, break clears
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else if (key_strobe) begin
			case (key_code)
				// movement, cursor keys
				8'h75: ctrl.up    <= key_pressed;
				8'h72: ctrl.down  <= key_pressed;
				8'h6B: ctrl.left  <= key_pressed;
				8'h74: ctrl.right <= key_pressed;

				// shooting direction
				8'h1D: ctrl.shot_up    <= key_pressed; // w
				8'h1C: ctrl.shot_left  <= key_pressed; // a
				8'h1B: ctrl.shot_down  <= key_pressed; // s
				8'h23: ctrl.shot_right <= key_pressed; // d

				8'h76: ctrl.coin   <= key_pressed; // esc
				8'h05: ctrl.start1 <= key_pressed; // f1
				8'h06: ctrl.start2 <= key_pressed; // f2
				default: begin
					// unmapped key, hold levels
				end
			endcase
		end
	end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 loader_req,
	input  logic                 cpu_req,
	input  logic                 snd_req,
	input  arcade_pkg::mem_req_t loader_mem_req,
	input  arcade_pkg::mem_req_t cpu_mem_req,
	input  arcade_pkg::mem_req_t snd_mem_req,
	input  logic                 mem_rvalid,
	input  logic [15:0]          mem_rdata,
	output logic                 loader_gnt,
	output logic                 cpu_gnt,
	output logic                 snd_gnt,
	output arcade_pkg::mem_req_t mem_req,
	output logic                 mem_valid,
	output logic                 loader_rvalid,
	output logic                 cpu_rvalid,
	output logic                 snd_rvalid,
	output logic [15:0]          rdata
);

	localparam int LAT = arcade_pkg::MEM_LATENCY;

	arcade_pkg::req_id_t rr_last;      // last of cpu/snd that won
	arcade_pkg::req_id_t gnt_id;
	arcade_pkg::req_id_t own_q [LAT];  // owner of each access in flight

	// ====================
	// grant, loader first
	// ====================
	assign loader_gnt = loader_req;
	assign cpu_gnt    = !loader_req && cpu_req && (!snd_req || rr_last == arcade_pkg::snd);
	assign snd_gnt    = !loader_req && snd_req && !cpu_gnt;
	assign mem_valid  = loader_gnt || cpu_gnt || snd_gnt;

	always_comb begin
		if (loader_req) begin
			gnt_id  = arcade_pkg::loader;
			mem_req = loader_mem_req;
		end else if (cpu_gnt) begin
			gnt_id  = arcade_pkg::cpu;
			mem_req = cpu_mem_req;
		end else begin
			gnt_id  = arcade_pkg::snd;
			mem_req = snd_mem_req;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rr_last <= arcade_pkg::snd; // cpu wins the first tie
			own_q   <= '{default: arcade_pkg::loader};
		end else begin
			if (cpu_gnt || snd_gnt) begin
				rr_last <= gnt_id;
			end
			own_q[0] <= gnt_id;
			for (int i = 1; i < LAT; i++) begin
				own_q[i] <= own_q[i-1];
			end
		end
	end

	// ====================
	// read return routing
	// ====================
	assign loader_rvalid = mem_rvalid && (own_q[LAT-1] == arcade_pkg::loader);
	assign cpu_rvalid    = mem_rvalid && (own_q[LAT-1] == arcade_pkg::cpu);
	assign snd_rvalid    = mem_rvalid && (own_q[LAT-1] == arcade_pkg::snd);
	assign rdata         = mem_rdata; // shared, rvalid picks the owner

endmodule

// File: design/rom_fetch_port.sv
`timescale 1ns/1ns

module rom_fetch_port #(
	parameter int ADDR_W = 15,
	parameter int BASE   = 0
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 dl_active,
	input  logic                 rd,
	input  logic [ADDR_W-1:0]    addr,
	input  logic                 gnt,
	input  logic                 rvalid,
	input  logic [15:0]          rdata,
	output logic                 req,
	output arcade_pkg::mem_req_t rd_req,
	output logic [7:0]           data,
	output logic                 valid
);

	localparam int IDX_W = ADDR_W - 1;

	logic [IDX_W-1:0]      word_idx;
	logic [IDX_W-1:0]      cache_idx;
	logic [15:0]           cache_word;
	logic                  cache_ok;
	logic                  busy;      // own fetch outstanding
	logic [IDX_W-1:0]      pend_idx;
	logic                  pend_hi;
	arcade_pkg::mem_addr_t fetch_addr;
	logic                  take;
	logic                  hit;

	assign word_idx = addr[ADDR_W-1:1];
	// rd in the valid cycle still belongs to the answered read
	assign take     = rd && !busy && !valid && !dl_active;
	assign hit      = cache_ok && (cache_idx == word_idx);

	assign rd_req = '{wr: 1'b0, addr: fetch_addr, be: 2'b11, wdata: 16'h0000};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req      <= 1'b0;
			busy     <= 1'b0;
			valid    <= 1'b0;
			cache_ok <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (gnt) begin
				req <= 1'b0;
			end
			if (dl_active) begin
				cache_ok <= 1'b0; // rom is being rewritten
			end
			if (take && hit) begin
				valid <= 1'b1;
			end else if (take) begin
				req  <= 1'b1;
				busy <= 1'b1;
			end
			if (rvalid) begin
				busy     <= 1'b0;
				valid    <= 1'b1;
				cache_ok <= !dl_active;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take && hit) begin
			data <= addr[0] ? cache_word[15:8] : cache_word[7:0];
		end
		if (take && !hit) begin
			pend_idx   <= word_idx;
			pend_hi    <= addr[0];
			fetch_addr <= arcade_pkg::mem_addr_t'(BASE) + arcade_pkg::mem_addr_t'(word_idx);
		end
		if (rvalid) begin
			cache_word <= rdata;
			cache_idx  <= pend_idx;
			data       <= pend_hi ? rdata[15:8] : rdata[7:0];
		end
	end

endmodule

// File: design/rom_loader.sv
`timescale 1ns/1ns

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [15:0]          dl_addr,
	input  logic [7:0]           dl_data,
	input  logic                 reset_btn,
	input  logic                 gnt,
	output logic                 req,
	output arcade_pkg::mem_req_t wr_req,
	output logic                 rom_loaded,
	output logic                 core_reset
);

	logic dl_active_q; // for the end of download edge

	// one pending write per strobe, strobes are spaced far enough apart
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
		end else if (dl_active && dl_wr) begin
			req <= 1'b1;
		end else if (gnt) begin
			req <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_active && dl_wr) begin
			wr_req.wr    <= 1'b1;
			wr_req.addr  <= dl_addr[15:1];                // byte to word
			wr_req.be    <= {dl_addr[0], ~dl_addr[0]};    // odd address = high byte
			wr_req.wdata <= {dl_data, dl_data};
		end
	end

	// ====================
	// load status and core reset
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_q <= 1'b0;
			rom_loaded  <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active) begin
				rom_loaded <= 1'b1;
			end
			core_reset <= !rom_loaded || reset_btn;
		end
	end

endmodule

// File: design/rom_store.sv
`timescale 1ns/1ns

module rom_store #(
	parameter int DEPTH = 32768
) (
	input  logic                 clk_sys,
	input  logic                 mem_valid,
	input  arcade_pkg::mem_req_t mem_req,
	output logic                 rvalid,
	output logic [15:0]          rdata
);

	localparam int LAT = arcade_pkg::MEM_LATENCY;

	logic [15:0] mem [DEPTH];
	logic        rv_q [LAT];
	logic [15:0] rd_q [LAT];

	// byte-strobe writes
	always_ff @(posedge clk_sys) begin
		if (mem_valid && mem_req.wr) begin
			if (mem_req.be[0]) begin
				mem[mem_req.addr][7:0] <= mem_req.wdata[7:0];
			end
			if (mem_req.be[1]) begin
				mem[mem_req.addr][15:8] <= mem_req.wdata[15:8];
			end
		end
	end

	// read pipeline, first stage samples the array
	always_ff @(posedge clk_sys) begin
		rv_q[0] <= mem_valid && !mem_req.wr; // writes return nothing
		if (mem_valid) begin
			rd_q[0] <= mem[mem_req.addr];
		end
		for (int i = 1; i < LAT; i++) begin
			rv_q[i] <= rv_q[i-1];
			rd_q[i] <= rd_q[i-1];
		end
	end

	assign rvalid = rv_q[LAT-1];
	assign rdata  = rd_q[LAT-1];

endmodule

// File: dv/tb_arcade_mem.sv
`timescale 1ns/1ns

module tb_arcade_mem;

	logic              clk_sys;
	logic              arst_n;
	logic              dl_active, dl_wr, reset_btn;
	logic [15:0]       dl_addr;
	logic [7:0]        dl_data;
	logic              key_strobe, key_pressed;
	logic [7:0]        key_code;
	logic [14:0]       cpu_rom_addr;
	logic              cpu_rom_rd;
	logic [13:0]       snd_rom_addr;
	logic              snd_rom_rd;
	logic [7:0]        cpu_rom_data, snd_rom_data;
	logic              cpu_rom_valid, snd_rom_valid;
	logic              rom_loaded, core_reset;
	arcade_pkg::ctrl_t ctrl;

	int          errors;
	string       test_name;
	logic [7:0]  shadow [65536];    // bytes as downloaded
	logic        cpu_pend, snd_pend; // read outstanding
	logic        cpu_hit, snd_hit;   // read expected to hit the cache
	logic [7:0]  cpu_exp, snd_exp;
	logic        cpu_cached, snd_cached;
	logic [13:0] cpu_word;
	logic [12:0] snd_word;
	logic [10:0] ctrl_exp;
	// in ctrl_t field order with up first
	logic [7:0]  key_codes [11] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h1D, 8'h1C,
		8'h1B, 8'h23, 8'h76, 8'h05, 8'h06};

	arcade_mem_top u_arcade_mem_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [7:0] ref_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	task automatic count_mismatch(input logic [15:0] exp_val, input logic [15:0] act_val);
		errors++;
		$display("error %s: expected %h actual %h", test_name, exp_val, act_val);
	endtask

	task automatic count_failure(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	// ====================
	// checks
	// ====================
	a_held_reset: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!rom_loaded |-> core_reset)
		else count_failure("core_reset went low before the rom was loaded");
	a_loaded: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(dl_active) |=> rom_loaded)
		else count_failure("rom_loaded did not rise after the download ended");
	a_btn_reset: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rom_loaded && reset_btn) |=> core_reset)
		else count_failure("core_reset low while the reset button was held");
	a_core_run: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rom_loaded && !reset_btn) |=> !core_reset)
		else count_failure("core_reset stayed high after load without the button");
	a_cpu_pend: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cpu_rom_valid |-> cpu_pend)
		else count_failure("cpu_rom_valid pulsed with no cpu read outstanding");
	a_cpu_data: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cpu_rom_valid |-> cpu_rom_data == cpu_exp)
		else count_mismatch(16'($sampled(cpu_exp)), 16'($sampled(cpu_rom_data)));
	a_cpu_hit: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cpu_hit |=> cpu_rom_valid)
		else count_failure("cpu cache hit gave no valid one cycle after the read");
	a_snd_pend: assert property (@(posedge clk_sys) disable iff (!arst_n)
		snd_rom_valid |-> snd_pend)
		else count_failure("snd_rom_valid pulsed with no sound read outstanding");
	a_snd_data: assert property (@(posedge clk_sys) disable iff (!arst_n)
		snd_rom_valid |-> snd_rom_data == snd_exp)
		else count_mismatch(16'($sampled(snd_exp)), 16'($sampled(snd_rom_data)));
	a_snd_hit: assert property (@(posedge clk_sys) disable iff (!arst_n)
		snd_hit |=> snd_rom_valid)
		else count_failure("sound cache hit gave no valid one cycle after the read");
	a_ctrl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		key_strobe |=> ctrl == ctrl_exp)
		else count_mismatch(16'($sampled(ctrl_exp)), 16'($sampled(ctrl)));

	// ====================
	// stimulus tasks
	// ====================
	task automatic send_byte(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= a;
		dl_data <= d;
		shadow[a] = d;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		repeat (3) @(posedge clk_sys); // strobes 4 cycles apart
	endtask

	task automatic set_download(input logic on);
		@(posedge clk_sys);
		dl_active <= on;
		cpu_cached = 1'b0; // ports drop their words on reload
		snd_cached = 1'b0;
	endtask

	task automatic wait_core_run();
		int n;
		n = 0;
		@(negedge clk_sys);
		while ((!rom_loaded || core_reset) && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rom_loaded || core_reset) begin
			count_failure("core never left reset with rom_loaded high");
		end
	endtask

	task automatic cpu_read(input logic [14:0] a);
		int n;
		@(posedge clk_sys);
		cpu_rom_rd   <= 1'b1;
		cpu_rom_addr <= a;
		cpu_pend     <= 1'b1;
		cpu_exp      <= shadow[{1'b0, a}];
		cpu_hit      <= cpu_cached && (cpu_word == a[14:1]);
		@(posedge clk_sys);
		cpu_rom_rd <= 1'b0;
		cpu_hit    <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!cpu_rom_valid && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (cpu_rom_valid) begin
			cpu_cached = 1'b1;
			cpu_word   = a[14:1];
		end else begin
			count_failure($sformatf("cpu_rom_valid never came for address %h", a));
		end
		@(posedge clk_sys);
		cpu_pend <= 1'b0;
	endtask

	task automatic snd_read(input logic [13:0] a);
		int n;
		@(posedge clk_sys);
		snd_rom_rd   <= 1'b1;
		snd_rom_addr <= a;
		snd_pend     <= 1'b1;
		snd_exp      <= shadow[16'h8000 | {2'b00, a}]; // sound image at 32768
		snd_hit      <= snd_cached && (snd_word == a[13:1]);
		@(posedge clk_sys);
		snd_rom_rd <= 1'b0;
		snd_hit    <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!snd_rom_valid && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (snd_rom_valid) begin
			snd_cached = 1'b1;
			snd_word   = a[13:1];
		end else begin
			count_failure($sformatf("snd_rom_valid never came for address %h", a));
		end
		@(posedge clk_sys);
		snd_pend <= 1'b0;
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		int i;
		@(posedge clk_sys);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		for (i = 0; i < 11; i++) begin
			if (key_codes[i] == code) begin
				ctrl_exp[10 - i] <= pressed;
			end
		end
		@(posedge clk_sys);
		key_strobe <= 1'b0;
	endtask

	// ====================
	// test sequence
	// ====================
	initial begin
		void'($urandom(32'h85d3));
		errors = 0;
		test_name = "reset_and_load";
		cpu_cached = 1'b0;
		snd_cached = 1'b0;
		arst_n <= 1'b0;
		dl_active <= 1'b0;
		dl_wr <= 1'b0;
		dl_addr <= '0;
		dl_data <= '0;
		reset_btn <= 1'b0;
		key_strobe <= 1'b0;
		key_pressed <= 1'b0;
		key_code <= '0;
		cpu_rom_addr <= '0;
		cpu_rom_rd <= 1'b0;
		snd_rom_addr <= '0;
		snd_rom_rd <= 1'b0;
		cpu_pend <= 1'b0;
		snd_pend <= 1'b0;
		cpu_hit <= 1'b0;
		snd_hit <= 1'b0;
		cpu_exp <= '0;
		snd_exp <= '0;
		ctrl_exp <= '0;
		repeat (16) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		a_after_reset: assert (core_reset && !rom_loaded)
			else count_mismatch(16'h0002, 16'({core_reset, rom_loaded}));

		set_download(1'b1);
		for (int i = 0; i < 512; i++) begin
			send_byte(16'(i), ref_byte(16'(i)));
		end
		for (int i = 32768; i < 33280; i++) begin
			send_byte(16'(i), ref_byte(16'(i)));
		end
		set_download(1'b0);
		wait_core_run();
		@(posedge clk_sys);
		reset_btn <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset_btn <= 1'b0;
		wait_core_run();

		test_name = "cpu_reads";
		for (int i = 0; i < 40; i++) begin
			cpu_read(15'($urandom % 512));
		end
		test_name = "snd_reads";
		for (int i = 0; i < 40; i++) begin
			snd_read(14'($urandom % 512));
		end

		test_name = "shared_access";
		for (int i = 0; i < 8; i++) begin
			fork
				cpu_read(15'(2 * i + 64));
				snd_read(14'(2 * i + 200));
			join
		end
		cpu_read(15'd100);
		cpu_read(15'd100); // same word hits the cache
		cpu_read(15'd101); // other byte of it
		snd_read(14'd301);
		snd_read(14'd300);

		test_name = "reload";
		cpu_read(15'd6);
		set_download(1'b1);
		send_byte(16'd6, 8'hC3);
		set_download(1'b0);
		wait_core_run();
		cpu_read(15'd6);
		cpu_read(15'd7);

		test_name = "keyboard";
		for (int i = 0; i < 11; i++) begin
			key_event(key_codes[i], 1'b1);
			key_event(8'h29, 1'b1); // not mapped
			key_event(key_codes[i], 1'b0);
		end
		repeat (2) @(posedge clk_sys);

		$display("closing report: %0d errors", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verilog.f
design/arcade_pkg.sv
design/rom_loader.sv
design/rom_fetch_port.sv
design/mem_arbiter.sv
design/rom_store.sv
design/key_mapper.sv
design/arcade_mem_top.sv
dv/tb_arcade_mem.sv
